/* hw/node_ring.sv */
/*
 * Node ring
 * Chains N ring nodes in id order, first to last, and closes the
 * chain with the ager stage that counts laps
 */
`timescale 1ns/1ns

module node_ring #(
  parameter int N = ring_pkg::N_NODES
) (
  input  logic                        clk_i,
  input  logic                        rst_n_i,
  input  ring_pkg::ring_cfg_t         cfg_i,
  input  ring_pkg::ring_pkt_t         slot_i,
  output ring_pkg::ring_pkt_t         slot_o,
  input  ring_pkg::ring_pkt_t [N-1:0] tx_i,
  output logic                [N-1:0] tx_credit_o,
  output ring_pkg::ring_pkt_t [N-1:0] rx_o,
  input  logic                [N-1:0] rx_credit_i,
  output logic                        drop_o
);
  import ring_pkg::*;

  // Entry 0 is the ring input, entry k the output of node k
  ring_pkt_t [N:0] chain;

  assign chain[0] = slot_i;

  // ========================================
  // Node chain, ids 1 to N
  // ========================================
  for (genvar g = 0; g < N; g++) begin : g_node
    ring_node #(
      .NODE_ID (g + 1)
    ) u_node (
      .clk_i       (clk_i),
      .rst_n_i     (rst_n_i),
      .cfg_i       (cfg_i),
      .slot_i      (chain[g]),
      .slot_o      (chain[g+1]),
      .tx_i        (tx_i[g]),
      .tx_credit_o (tx_credit_o[g]),
      .rx_o        (rx_o[g]),
      .rx_credit_i (rx_credit_i[g])
    );
  end

  // The last node feeds the ager, which drives the ring output
  ring_ager u_ager (
    .clk_i     (clk_i),
    .rst_n_i   (rst_n_i),
    .max_age_i (cfg_i.max_age),
    .slot_i    (chain[N]),
    .slot_o    (slot_o),
    .drop_o    (drop_o)
  );

endmodule

/* hw/ring_ager.sv */
/*
 * Ring ager
 * Closing stage of the ring. Adds one lap to every passing packet and
 * removes packets that have reached the maximum lap count, pulsing a
 * drop flag for each one removed
 */
`timescale 1ns/1ns

module ring_ager (
  input  logic                      clk_i,
  input  logic                      rst_n_i,
  input  logic [ring_pkg::AGE_W-1:0] max_age_i,
  input  ring_pkg::ring_pkt_t       slot_i,
  output ring_pkg::ring_pkt_t       slot_o,
  output logic                      drop_o
);
  import ring_pkg::*;

  ring_pkt_t slot_q;
  logic      slot_vld_q;
  logic      drop_q;
  logic      overage;

  // A packet at the limit is never incremented, so the lap count cannot wrap
  assign overage = slot_i.valid && (slot_i.age >= max_age_i);

  // ========================================
  // Slot register with lap increment
  // ========================================
  always_ff @(posedge clk_i) begin
    slot_q     <= slot_i;
    slot_q.age <= slot_i.age + AGE_W'(1);
  end

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      slot_vld_q <= 1'b0;
      drop_q     <= 1'b0;
    end else begin
      // An overaged packet leaves an empty slot behind
      slot_vld_q <= slot_i.valid && !overage;
      drop_q     <= overage;
    end
  end

  always_comb begin
    slot_o       = slot_q;
    slot_o.valid = slot_vld_q;
  end

  assign drop_o = drop_q;

endmodule

/* hw/ring_cfg_regs.sv */
/*
 * Ring configuration registers
 * Holds the node enable mask and the lap limit that steer the ring,
 * and counts packets dropped by the ager in a saturating counter
 */
`timescale 1ns/1ns

module ring_cfg_regs (
  input  logic                           clk_i,
  input  logic                           rst_n_i,
  input  logic                           cfg_we_i,
  input  ring_pkg::cfg_op_e              cfg_addr_i,
  input  logic [ring_pkg::CFG_DATA_W-1:0] cfg_wdata_i,
  output logic [ring_pkg::CFG_DATA_W-1:0] cfg_rdata_o,
  input  logic                           drop_i,
  output ring_pkg::ring_cfg_t            cfg_o
);
  import ring_pkg::*;

  logic [ENABLE_W-1:0]   enable_q;
  logic [AGE_W-1:0]      max_age_q;
  logic [CFG_DATA_W-1:0] drop_cnt_q;

  // ========================================
  // Register writes and drop counting
  // ========================================
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      enable_q   <= '1;
      max_age_q  <= '1;
      drop_cnt_q <= '0;
    end else begin
      if (cfg_we_i && (cfg_addr_i == CFG_ENABLE)) begin
        enable_q <= cfg_wdata_i[ENABLE_W-1:0];
      end
      if (cfg_we_i && (cfg_addr_i == CFG_MAX_AGE)) begin
        max_age_q <= cfg_wdata_i[AGE_W-1:0];
      end
      // Any write clears the count, and the clear wins over a drop
      if (cfg_we_i && (cfg_addr_i == CFG_DROP_COUNT)) begin
        drop_cnt_q <= '0;
      end else if (drop_i && (drop_cnt_q != '1)) begin
        drop_cnt_q <= drop_cnt_q + 1'b1;
      end
    end
  end

  // Reads decode the address directly, unused addresses return zero
  always_comb begin
    case (cfg_addr_i)
      CFG_ENABLE:     cfg_rdata_o = CFG_DATA_W'(enable_q);
      CFG_MAX_AGE:    cfg_rdata_o = CFG_DATA_W'(max_age_q);
      CFG_DROP_COUNT: cfg_rdata_o = drop_cnt_q;
      default:        cfg_rdata_o = '0;
    endcase
  end

  assign cfg_o.enable  = enable_q;
  assign cfg_o.max_age = max_age_q;

endmodule

/* hw/ring_node.sv */
/*
 * Ring node
 * One stop on the slotted ring. Ejects packets addressed to this node
 * while receive credits remain, and launches buffered host packets into
 * empty or freed slots. A disabled node passes every slot through
 */
`timescale 1ns/1ns

module ring_node #(
  parameter int NODE_ID = 1
) (
  input  logic                clk_i,
  input  logic                rst_n_i,
  input  ring_pkg::ring_cfg_t cfg_i,
  input  ring_pkg::ring_pkt_t slot_i,
  output ring_pkg::ring_pkt_t slot_o,
  input  ring_pkg::ring_pkt_t tx_i,
  output logic                tx_credit_o,
  output ring_pkg::ring_pkt_t rx_o,
  input  logic                rx_credit_i
);
  import ring_pkg::*;

  localparam logic [NODE_ID_W-1:0] MY_ID = NODE_ID_W'(NODE_ID);
  localparam int RX_CNT_W = $clog2(RX_CREDITS + 1);
  localparam int TX_CNT_W = $clog2(TX_DEPTH + 1);
  localparam int TX_PTR_W = (TX_DEPTH > 1) ? $clog2(TX_DEPTH) : 1;

  ring_pkt_t            tx_mem [TX_DEPTH];
  logic [TX_PTR_W-1:0]  tx_wr_ptr;
  logic [TX_PTR_W-1:0]  tx_rd_ptr;
  logic [TX_CNT_W-1:0]  tx_cnt;
  logic [RX_CNT_W-1:0]  rx_cnt;
  logic                 node_en;
  logic                 eject;
  logic                 launch;
  ring_pkt_t            launch_pkt;
  ring_pkt_t            slot_d;
  ring_pkt_t            slot_q;
  logic                 slot_vld_q;
  ring_pkt_t            rx_q;
  logic                 rx_vld_q;
  logic                 tx_credit_q;

  // ========================================
  // Eject and inject decisions
  // ========================================
  assign node_en = cfg_i.enable[NODE_ID];

  // Without a credit the packet stays on the ring and returns a lap later
  assign eject = node_en && slot_i.valid && (slot_i.dst == MY_ID) && (rx_cnt != '0);

  // A slot is free when it arrives empty or its packet leaves here
  assign launch = node_en && (tx_cnt != '0) && (!slot_i.valid || eject);

  always_comb begin
    launch_pkt       = tx_mem[tx_rd_ptr];
    launch_pkt.valid = 1'b1;
    launch_pkt.src   = MY_ID;
    launch_pkt.age   = '0;
    slot_d           = slot_i;
    if (launch) begin
      slot_d = launch_pkt;
    end else if (eject) begin
      slot_d.valid = 1'b0;
    end
  end

  // Data registers of the outgoing slot, the receive port and the transmit buffer
  always_ff @(posedge clk_i) begin
    slot_q <= slot_d;
    if (eject) begin
      rx_q <= slot_i;
    end
    if (tx_i.valid) begin
      tx_mem[tx_wr_ptr] <= tx_i;
    end
  end

  // ========================================
  // Control state and credit counters
  // ========================================
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      slot_vld_q  <= 1'b0;
      rx_vld_q    <= 1'b0;
      tx_credit_q <= 1'b0;
      tx_wr_ptr   <= '0;
      tx_rd_ptr   <= '0;
      tx_cnt      <= '0;
      rx_cnt      <= RX_CNT_W'(RX_CREDITS);
    end else begin
      slot_vld_q  <= slot_d.valid;
      rx_vld_q    <= eject;
      tx_credit_q <= launch;
      if (tx_i.valid) begin
        tx_wr_ptr <= (tx_wr_ptr == TX_PTR_W'(TX_DEPTH - 1)) ? '0 : tx_wr_ptr + 1'b1;
      end
      if (launch) begin
        tx_rd_ptr <= (tx_rd_ptr == TX_PTR_W'(TX_DEPTH - 1)) ? '0 : tx_rd_ptr + 1'b1;
      end
      // Host holds a credit for every push, so the buffer never overflows
      tx_cnt <= tx_cnt + TX_CNT_W'(tx_i.valid) - TX_CNT_W'(launch);
      rx_cnt <= rx_cnt + RX_CNT_W'(rx_credit_i) - RX_CNT_W'(eject);
    end
  end

  always_comb begin
    slot_o       = slot_q;
    slot_o.valid = slot_vld_q;
    rx_o         = rx_q;
    rx_o.valid   = rx_vld_q;
  end

  // Credit pulse lines up with the launched packet leaving on slot_o
  assign tx_credit_o = tx_credit_q;

endmodule

/* hw/ring_pkg.sv */
/*
 * Slotted packet ring package
 * Shared sizes, the ring packet and configuration structs, and the
 * configuration register addresses used by every ring block
 */
package ring_pkg;

  // ========================================
  // Ring geometry and field widths
  // ========================================
  localparam int N_NODES    = 7;
  localparam int NODE_ID_W  = 3;
  localparam int PAYLOAD_W  = 16;
  localparam int AGE_W      = 4;
  localparam int PKT_W      = 40;
  localparam int PAD_W      = PKT_W - (1 + 2 * NODE_ID_W + AGE_W + PAYLOAD_W);
  // One enable bit per node id, bit 0 stays unused since id 0 marks no node
  localparam int ENABLE_W   = 1 << NODE_ID_W;
  localparam int CFG_DATA_W = 16;

  // Credits a node starts with toward its host receive queue
  localparam int RX_CREDITS = 4;
  // Transmit buffer depth, also the host's starting transmit credits
  localparam int TX_DEPTH   = 2;

  // ========================================
  // Ring slot contents
  // ========================================
  typedef struct packed {
    logic                 valid;
    logic [NODE_ID_W-1:0] src;
    logic [NODE_ID_W-1:0] dst;
    logic [AGE_W-1:0]     age;
    logic [PAYLOAD_W-1:0] payload;
    logic [PAD_W-1:0]     pad;
  } ring_pkt_t;

  // Steering values broadcast from the register block
  typedef struct packed {
    logic [ENABLE_W-1:0] enable;
    logic [AGE_W-1:0]    max_age;
  } ring_cfg_t;

  typedef enum logic [1:0] {
    CFG_ENABLE     = 2'd0,
    CFG_MAX_AGE    = 2'd1,
    CFG_DROP_COUNT = 2'd2
  } cfg_op_e;

endpackage

/* hw/ring_top.sv */
/*
 * Slotted ring top level
 * Closes the node ring into a loop and places the configuration
 * register block beside it. Hosts attach through per-node transmit
 * and receive ports with credit return
 */
`timescale 1ns/1ns

module ring_top (
  input  logic                                           clk_i,
  input  logic                                           rst_n_i,
  // ========================================
  // Host ports, entry k serves node k+1
  // ========================================
  input  ring_pkg::ring_pkt_t [ring_pkg::N_NODES-1:0]    tx_i,
  output logic                [ring_pkg::N_NODES-1:0]    tx_credit_o,
  output ring_pkg::ring_pkt_t [ring_pkg::N_NODES-1:0]    rx_o,
  input  logic                [ring_pkg::N_NODES-1:0]    rx_credit_i,
  // ========================================
  // Configuration port
  // ========================================
  input  logic                                           cfg_we_i,
  input  ring_pkg::cfg_op_e                              cfg_addr_i,
  input  logic                [ring_pkg::CFG_DATA_W-1:0] cfg_wdata_i,
  output logic                [ring_pkg::CFG_DATA_W-1:0] cfg_rdata_o
);
  import ring_pkg::*;

  // Ager output returning to node 1
  ring_pkt_t ring_loop;
  ring_cfg_t ring_cfg;
  logic      ager_drop;

  // The ring output wraps straight back to its input
  node_ring #(
    .N (N_NODES)
  ) u_node_ring (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .cfg_i       (ring_cfg),
    .slot_i      (ring_loop),
    .slot_o      (ring_loop),
    .tx_i        (tx_i),
    .tx_credit_o (tx_credit_o),
    .rx_o        (rx_o),
    .rx_credit_i (rx_credit_i),
    .drop_o      (ager_drop)
  );

  // Enable mask and lap limit fan out to every node and the ager
  ring_cfg_regs u_cfg_regs (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .cfg_we_i    (cfg_we_i),
    .cfg_addr_i  (cfg_addr_i),
    .cfg_wdata_i (cfg_wdata_i),
    .cfg_rdata_o (cfg_rdata_o),
    .drop_i      (ager_drop),
    .cfg_o       (ring_cfg)
  );

endmodule

/* run_sim.sh */
#!/bin/sh
# Build the ring testbench with Verilator, run it and check the log
rm -rf obj_dir sim.log
verilator --binary --assert -f vlog.f --top-module tb_ring_top -o tb_ring_top \
  && ./obj_dir/tb_ring_top > sim.log 2>&1 \
  || echo "run_sim: build or run stopped early"
cat sim.log 2>/dev/null
grep -qx "Simulation PASSED" sim.log \
  && echo "run_sim: test passed" \
  || { echo "run_sim: test failed"; exit 1; }

/* sim/tb_clk_gen.sv */
/*
 * Testbench clock and reset
 * Free-running clock and an active low reset held for a set number of cycles
 */
`timescale 1ns/1ns

module tb_clk_gen #(
  parameter int PERIOD_NS  = 100,
  parameter int RST_CYCLES = 5
) (
  output logic clk_o,
  output logic rst_n_o
);

  initial begin
    clk_o = 1'b0;
    forever #(PERIOD_NS / 2) clk_o = ~clk_o;
  end

  // Reset is released on a falling edge, away from the sampling edge
  initial begin
    rst_n_o = 1'b0;
    repeat (RST_CYCLES) @(posedge clk_o);
    @(negedge clk_o);
    rst_n_o = 1'b1;
  end

endmodule

/* sim/tb_ring_top.sv */
/*
 * Slotted ring testbench
 * Host models with their own credit counts serve all nodes, a scoreboard
 * keyed by source, destination and payload tracks packets in flight, and
 * assertions check delivery, credits, back-pressure, drops and config
 */
`timescale 1ns/1ns

module tb_ring_top;
  import ring_pkg::*;

  localparam int CLK_PERIOD  = 100;
  localparam int LAP         = N_NODES + 1;
  localparam int RAND_PKTS   = 40;
  localparam int BP_PKTS     = 8;
  localparam int DROP_PKTS   = 6;
  localparam int HOLD_LAPS   = 5;
  localparam int KEY_W       = 2 * NODE_ID_W + PAYLOAD_W;
  // Rough cycle budget of all phases that the watchdog allows four times over
  localparam int TEST_CYCLES = (RAND_PKTS + BP_PKTS + DROP_PKTS + HOLD_LAPS + 12) * LAP + 100;

  logic                       clk;
  logic                       rst_n;
  ring_pkt_t [N_NODES-1:0]    tx_vec;
  logic      [N_NODES-1:0]    tx_credit;
  ring_pkt_t [N_NODES-1:0]    rx_vec;
  logic      [N_NODES-1:0]    rx_credit;
  logic      [N_NODES-1:0]    rx_valid;
  logic                       cfg_we;
  cfg_op_e                    cfg_addr;
  logic      [CFG_DATA_W-1:0] cfg_wdata;
  logic      [CFG_DATA_W-1:0] cfg_rdata;

  // Host state where index k belongs to node k+1
  ring_pkt_t          tx_q [N_NODES][$];
  int                 tx_cred [N_NODES];
  int                 rx_avail [N_NODES];
  int                 rx_owed [N_NODES];
  logic [N_NODES-1:0] rx_hold;
  logic [N_NODES-1:0] quiet;
  logic               hosts_on;
  logic               sb [logic [KEY_W-1:0]];
  logic [7:0]         seq;

  tb_clk_gen #(.PERIOD_NS(CLK_PERIOD), .RST_CYCLES(5)) u_clk_gen (.clk_o(clk), .rst_n_o(rst_n));

  ring_top dut_i (
    .clk_i       (clk),
    .rst_n_i     (rst_n),
    .tx_i        (tx_vec),
    .tx_credit_o (tx_credit),
    .rx_o        (rx_vec),
    .rx_credit_i (rx_credit),
    .cfg_we_i    (cfg_we),
    .cfg_addr_i  (cfg_addr),
    .cfg_wdata_i (cfg_wdata),
    .cfg_rdata_o (cfg_rdata)
  );

  always_comb begin
    for (int n = 0; n < N_NODES; n++) begin
      rx_valid[n] = rx_vec[n].valid;
    end
  end

  task automatic fail_check(input string msg);
    $display("Fail at %0t ns: %s", $time, msg);
    $display("Simulation FAILED");
    $fatal(1, "stopped at the first error");
  endtask

  // A node marked quiet is disabled, so it neither launches nor ejects
  assert property (@(negedge clk) disable iff (!rst_n) ((tx_credit | rx_valid) & quiet) == '0)
    else fail_check("a disabled node launched or ejected a packet");

  // ========================================
  // Host models
  // ========================================
  // Checks one node's outputs and then drives its host inputs for the next cycle
  task automatic serve_host(input int n);
    logic [KEY_W-1:0] key;
    ring_pkt_t        pkt;
    key = {rx_vec[n].src, rx_vec[n].dst, rx_vec[n].payload};
    pkt = '0;
    if (tx_credit[n]) begin
      assert (tx_cred[n] < TX_DEPTH)
        else fail_check($sformatf("node %0d credit pulse with no packet pending", n + 1));
      tx_cred[n]++;
    end
    if (rx_valid[n]) begin
      assert (rx_avail[n] > 0)
        else fail_check($sformatf("node %0d delivered without a receive credit", n + 1));
      assert (rx_vec[n].dst == NODE_ID_W'(n + 1) && sb.exists(key))
        else fail_check($sformatf("node %0d got unexpected packet key 0x%h", n + 1, key));
      sb.delete(key);
      rx_avail[n]--;
      rx_owed[n]++;
    end
    // Pushes only while a transmit credit is held and leaves random gaps
    if (tx_q[n].size() > 0 && tx_cred[n] > 0 && ($urandom % 4) != 0) begin
      pkt = tx_q[n].pop_front();
      pkt.valid = 1'b1;
      tx_cred[n]--;
    end
    tx_vec[n] <= pkt;
    rx_credit[n] <= 1'b0;
    if (!rx_hold[n] && rx_owed[n] > 0) begin
      rx_credit[n] <= 1'b1;
      rx_owed[n]--;
      rx_avail[n]++;
    end
  endtask

  always @(negedge clk) begin
    if (hosts_on) begin
      for (int n = 0; n < N_NODES; n++) begin
        serve_host(n);
      end
    end
  end

  // Queues one packet at host src and leaves the source id to the node
  task automatic send_pkt(input int src, input int dst, input bit expect_rx);
    ring_pkt_t pkt;
    pkt = '0;
    pkt.dst = NODE_ID_W'(dst);
    pkt.payload = {8'($urandom), seq};
    seq++;
    if (expect_rx) begin
      sb[{NODE_ID_W'(src), pkt.dst, pkt.payload}] = 1'b1;
    end
    tx_q[src - 1].push_back(pkt);
  endtask

  // Random source id other than the one given
  function automatic int other_node(input int skip);
    int s;
    s = 1 + int'($urandom % (N_NODES - 1));
    return (s >= skip) ? s + 1 : s;
  endfunction

  function automatic bit traffic_idle();
    for (int n = 0; n < N_NODES; n++) begin
      if (tx_q[n].size() != 0 || tx_cred[n] != TX_DEPTH || rx_owed[n] != 0) begin
        return 1'b0;
      end
    end
    return sb.num() == 0;
  endfunction

  task automatic wait_idle();
    while (!traffic_idle()) @(posedge clk);
  endtask

  // ========================================
  // Configuration port access
  // ========================================
  task automatic write_cfg(input cfg_op_e addr, input logic [CFG_DATA_W-1:0] data);
    @(negedge clk);
    cfg_we    <= 1'b1;
    cfg_addr  <= addr;
    cfg_wdata <= data;
    @(negedge clk);
    cfg_we    <= 1'b0;
  endtask

  // Samples the read data a quarter period after the address changes
  task automatic expect_cfg(input cfg_op_e addr, input logic [CFG_DATA_W-1:0] exp);
    @(negedge clk);
    cfg_addr <= addr;
    #(CLK_PERIOD / 4);
    assert (cfg_rdata == exp)
      else fail_check($sformatf("%s read 0x%04h, expected 0x%04h", addr.name(), cfg_rdata, exp));
  endtask

  initial begin
    int s;
    void'($urandom(32'h2f9b_f9ea));
    tx_vec <= '0;
    rx_credit <= '0;
    cfg_we <= 1'b0;
    cfg_addr <= CFG_ENABLE;
    cfg_wdata <= '0;
    rx_hold = '0;
    quiet = '0;
    hosts_on = 1'b0;
    seq = '0;
    for (int n = 0; n < N_NODES; n++) begin
      tx_cred[n] = TX_DEPTH;
      rx_avail[n] = RX_CREDITS;
      rx_owed[n] = 0;
    end
    @(posedge rst_n);
    @(negedge clk);
    assert (tx_credit == '0 && rx_valid == '0) else fail_check("outputs active after reset");
    expect_cfg(CFG_ENABLE, 16'h00ff);
    expect_cfg(CFG_MAX_AGE, 16'd15);
    expect_cfg(CFG_DROP_COUNT, 16'd0);
    @(posedge clk);
    hosts_on = 1'b1;

    // Random delivery between all nodes with dst never equal to src
    for (int i = 0; i < RAND_PKTS; i++) begin
      s = 1 + int'($urandom % N_NODES);
      send_pkt(s, other_node(s), 1'b1);
      if (i % N_NODES == N_NODES - 1) @(posedge clk);
    end
    wait_idle();

    // Node 2 holds its credits, so four packets keep circling the ring
    rx_hold[1] = 1'b1;
    for (int i = 0; i < BP_PKTS; i++) begin
      send_pkt(other_node(2), 2, 1'b1);
    end
    repeat (HOLD_LAPS * LAP) @(posedge clk);
    assert (rx_avail[1] == 0 && sb.num() == BP_PKTS - RX_CREDITS)
      else fail_check($sformatf("held node 2 left %0d packets in flight", sb.num()));
    rx_hold[1] = 1'b0;
    wait_idle();

    // With node 5 off and a short lap limit every packet to it is dropped
    write_cfg(CFG_ENABLE, 16'h00df);
    write_cfg(CFG_MAX_AGE, 16'd2);
    expect_cfg(CFG_ENABLE, 16'h00df);
    expect_cfg(CFG_MAX_AGE, 16'd2);
    @(posedge clk);
    quiet[4] = 1'b1;
    for (int i = 0; i < DROP_PKTS; i++) begin
      send_pkt(other_node(5), 5, 1'b0);
    end
    wait_idle();
    repeat (5 * LAP) @(posedge clk);
    expect_cfg(CFG_DROP_COUNT, 16'(DROP_PKTS));
    write_cfg(CFG_DROP_COUNT, 16'd0);
    expect_cfg(CFG_DROP_COUNT, 16'd0);
    @(posedge clk);
    quiet[4] = 1'b0;
    write_cfg(CFG_MAX_AGE, 16'd15);
    write_cfg(CFG_ENABLE, 16'h00ff);
    expect_cfg(CFG_MAX_AGE, 16'd15);

    // Node 3 off keeps its buffered packets and skips one addressed to it
    write_cfg(CFG_ENABLE, 16'h00f7);
    expect_cfg(CFG_ENABLE, 16'h00f7);
    @(posedge clk);
    quiet[2] = 1'b1;
    send_pkt(3, 1, 1'b1);
    send_pkt(3, 6, 1'b1);
    send_pkt(1, 3, 1'b1);
    repeat (3 * LAP) @(posedge clk);
    assert (tx_cred[2] == 0 && tx_q[2].size() == 0 && sb.num() == 3)
      else fail_check("disabled node 3 did not hold its traffic");
    quiet[2] = 1'b0;
    write_cfg(CFG_ENABLE, 16'h00ff);
    wait_idle();
    repeat (LAP) @(posedge clk);
    // No packet ages out while the lap limit is back at 15
    expect_cfg(CFG_DROP_COUNT, 16'd0);
    $display("Simulation PASSED");
    $finish;
  end

  initial begin
    #(TEST_CYCLES * 4 * CLK_PERIOD);
    $display("Timeout: the ring tests did not finish within %0d cycles", TEST_CYCLES * 4);
    $display("Simulation FAILED");
    $fatal(1, "watchdog expired");
  end

endmodule

/* vlog.f */
hw/ring_pkg.sv
hw/ring_node.sv
hw/ring_ager.sv
hw/node_ring.sv
hw/ring_cfg_regs.sv
hw/ring_top.sv
sim/tb_clk_gen.sv
sim/tb_ring_top.sv
